// File: flist.f
logic/shelf_pkg.sv
logic/pixel_locator.sv
logic/color_classifier.sv
logic/rect_tally.sv
logic/checkout_ctrl.sv
logic/shelf_top.sv
sim/tb_shelf.sv

// File: logic/checkout_ctrl.sv
`timescale 1ns/1ps

module checkout_ctrl import shelf_pkg::*; (
    input  logic       sys_clk,
    input  logic       sys_rst_n,
    input  logic       i_frame_done,
    input  label_bus_t i_label,
    input  byte_t      i_user,
    output byte_t      o_num,
    output byte_t      o_money,
    output byte_t      o_payment,
    output byte_t      o_user,
    output mode_t      o_pattern
);

    function automatic byte_t price_of(label_t lbl);
        byte_t p;
        case (lbl)
            4'd1:    p = PRICE_1;
            4'd2:    p = PRICE_2;
            4'd3:    p = PRICE_3;
            4'd4:    p = PRICE_4;
            4'd7:    p = PRICE_7;
            default: p = '0;
        endcase
        return p;
    endfunction

    logic [$clog2(RECT_NUM)-1:0] scan_idx;
    logic                        scan_on;
    logic                        settle;
    label_t                      cur_label;
    byte_t                       run_num;
    byte_t                       run_money;
    byte_t                       last_num;
    byte_t                       last_money;
    logic [15:0]                 hold_cnt;

    assign cur_label = i_label[scan_idx*4 +: 4];

    // cycles spent showing a payment or a warning
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n)
            hold_cnt <= '0;
        else if (o_pattern == MODE_PAY || o_pattern == MODE_WARN) begin
            if (hold_cnt != '1)
                hold_cnt <= hold_cnt + 1'b1;
        end else
            hold_cnt <= '0;
    end

    // ****************************************
    // label scan, then one settle cycle
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            scan_idx   <= '0;
            scan_on    <= 1'b0;
            settle     <= 1'b0;
            run_num    <= '0;
            run_money  <= '0;
            last_num   <= '0;
            last_money <= '0;
            o_num      <= '0;
            o_money    <= '0;
            o_payment  <= '0;
            o_user     <= '0;
            o_pattern  <= MODE_FREE;
        end else begin
            settle <= 1'b0;
            if (i_frame_done) begin
                scan_on  <= 1'b1;
                scan_idx <= '0;
            end else if (scan_on) begin
                if (cur_label != '0) begin
                    run_num   <= run_num + 1'b1;
                    run_money <= run_money + price_of(cur_label);
                end
                if (scan_idx == RECT_NUM - 1) begin
                    scan_on <= 1'b0;
                    settle  <= 1'b1;
                end else begin
                    scan_idx <= scan_idx + 1'b1;
                end
            end else if (settle) begin
                run_num   <= '0;
                run_money <= '0;
                case (o_pattern)
                    MODE_FREE: begin
                        if (run_num < o_num) begin
                            // something left the shelf without a user
                            o_num     <= '0;
                            o_money   <= '0;
                            o_payment <= '0;
                            o_pattern <= MODE_WARN;
                        end else if (i_user == USER_RESTOCK) begin
                            o_pattern <= MODE_PUT;
                        end else if (i_user != USER_NONE) begin
                            last_num   <= o_num;
                            last_money <= o_money;
                            o_user     <= i_user;
                            o_pattern  <= MODE_GET;
                        end else begin
                            o_num     <= run_num;
                            o_money   <= run_money;
                            o_payment <= '0;
                        end
                    end
                    MODE_GET: begin
                        if (i_user == USER_NONE) begin
                            o_num     <= last_num;
                            o_money   <= last_money;
                            o_payment <= last_money - run_money;
                            o_pattern <= MODE_PAY;
                        end
                    end
                    MODE_PUT: begin
                        if (i_user == USER_NONE) begin
                            o_num     <= run_num;
                            o_pattern <= MODE_FREE;
                        end
                    end
                    default: begin
                        // pay or warn, leave after the hold
                        if (hold_cnt > HOLD_CYCLES) begin
                            o_num     <= run_num;
                            o_pattern <= MODE_FREE;
                            if (o_pattern == MODE_PAY)
                                o_user <= i_user;
                        end
                    end
                endcase
            end
        end
    end

endmodule

// File: logic/color_classifier.sv
`timescale 1ns/1ps

module color_classifier import shelf_pkg::*; (
    input  logic   sys_clk,
    input  logic   sys_rst_n,
    input  logic   i_valid,
    input  pix_t   i_pix,
    input  logic   i_in_win,
    input  sum_t   i_match_err,
    input  sum_t   i_v_min,
    input  sum_t   i_v_max,
    input  sum_t   i_white_min,
    output color_t o_color,
    output logic   o_valid,
    output pix_t   o_pix
);

    function automatic chan_t abs_diff(chan_t a, chan_t b);
        return (a > b) ? a - b : b - a;
    endfunction

    // L1 distance from a palette hue
    function automatic sum_t hue_dist(logic [17:0] pal, chan_t r, chan_t g, chan_t b);
        sum_t d;
        d = sum_t'(abs_diff(r, pal[17:12])) + sum_t'(abs_diff(g, pal[11:6])) +
            sum_t'(abs_diff(b, pal[5:0]));
        return d;
    endfunction

    chan_t  ch_r;
    chan_t  ch_g;
    chan_t  ch_b;
    sum_t   ch_sum;
    logic   in_range;
    logic   hit_red;
    logic   hit_green;
    logic   hit_blue;
    logic   hit_yellow;
    color_t color_next;
    logic   valid_d1;
    pix_t   pix_d1;
    pix_t   show_pix;

    // 565 to 666
    assign ch_r   = {i_pix[15:11], 1'b0};
    assign ch_g   = i_pix[10:5];
    assign ch_b   = {i_pix[4:0], 1'b0};
    assign ch_sum = sum_t'(ch_r) + sum_t'(ch_g) + sum_t'(ch_b);

    assign in_range   = (ch_sum >= i_v_min) && (ch_sum <= i_v_max);
    assign hit_red    = in_range && (hue_dist(PAL_RED, ch_r, ch_g, ch_b) <= i_match_err);
    assign hit_green  = in_range && (hue_dist(PAL_GREEN, ch_r, ch_g, ch_b) <= i_match_err);
    assign hit_blue   = in_range && (hue_dist(PAL_BLUE, ch_r, ch_g, ch_b) <= i_match_err);
    assign hit_yellow = in_range && (hue_dist(PAL_YELLOW, ch_r, ch_g, ch_b) <= i_match_err);

    always_comb begin
        if (hit_red)
            color_next = COL_RED;
        else if (hit_green)
            color_next = COL_GREEN;
        else if (hit_blue)
            color_next = COL_BLUE;
        else if (hit_yellow)
            color_next = COL_YELLOW;
        else if (ch_sum > i_white_min)
            color_next = COL_WHITE;
        else
            color_next = COL_BLACK;
    end

    // ****************************************
    // stage 1, class beside the locator
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            o_color  <= COL_RED;
            valid_d1 <= 1'b0;
        end else begin
            valid_d1 <= i_valid;
            if (i_valid)
                o_color <= color_next;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (i_valid)
            pix_d1 <= i_pix;
    end

    always_comb begin
        case (o_color)
            COL_RED:    show_pix = SHOW_RED;
            COL_GREEN:  show_pix = SHOW_GREEN;
            COL_BLUE:   show_pix = SHOW_BLUE;
            COL_YELLOW: show_pix = SHOW_YELLOW;
            COL_WHITE:  show_pix = SHOW_WHITE;
            default:    show_pix = SHOW_BLACK;
        endcase
    end

    // ****************************************
    // stage 2, recolor inside the window only
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            o_valid <= 1'b0;
            o_pix   <= '0;
        end else begin
            o_valid <= valid_d1;
            o_pix   <= i_in_win ? show_pix : pix_d1;
        end
    end

endmodule

// File: logic/pixel_locator.sv
`timescale 1ns/1ps

module pixel_locator import shelf_pkg::*; (
    input  logic   sys_clk,
    input  logic   sys_rst_n,
    input  logic   i_valid,
    output logic   o_valid,
    output coord_t o_x,
    output coord_t o_y,
    output logic   o_in_win
);

    // position of the next valid pixel
    coord_t x_cnt;
    coord_t y_cnt;
    logic   in_win;

    assign in_win = (x_cnt >= WIN_X1) && (x_cnt <= WIN_X2) &&
                    (y_cnt >= WIN_Y1) && (y_cnt <= WIN_Y2);

    // raster counters
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (i_valid) begin
            if (x_cnt == coord_t'(FRAME_W - 1)) begin
                x_cnt <= '0;
                if (y_cnt == coord_t'(FRAME_H - 1))
                    y_cnt <= '0;
                else
                    y_cnt <= y_cnt + 1'b1;
            end else begin
                x_cnt <= x_cnt + 1'b1;
            end
        end
    end

    // position travels one cycle behind the pixel
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            o_valid  <= 1'b0;
            o_x      <= '0;
            o_y      <= '0;
            o_in_win <= 1'b0;
        end else begin
            o_valid  <= i_valid;
            o_x      <= x_cnt;
            o_y      <= y_cnt;
            o_in_win <= i_valid && in_win;
        end
    end

endmodule

// File: logic/rect_tally.sv
`timescale 1ns/1ps

module rect_tally import shelf_pkg::*; (
    input  logic       sys_clk,
    input  logic       sys_rst_n,
    input  logic       i_valid,
    input  coord_t     i_x,
    input  coord_t     i_y,
    input  logic       i_in_win,
    input  color_t     i_color,
    input  rect_bus_t  i_item,
    output rect_bus_t  o_item,
    output label_bus_t o_label,
    output logic       o_frame_done
);

    // rectangle bytes are in units of 4 pixels
    function automatic logic in_rect(rect_t r, coord_t x, coord_t y);
        coord_t cx;
        coord_t cy;
        cx = x >> 2;
        cy = y >> 2;
        return (cx >= r[31:24]) && (cy >= r[23:16]) && (cx <= r[15:8]) && (cy <= r[7:0]);
    endfunction

    function automatic label_t pick_label(tally_t t_red, tally_t t_green, tally_t t_blue,
                                          tally_t t_yellow, tally_t t_black);
        label_t lbl;
        if (t_green > TALLY_MIN)
            lbl = 4'd1;
        else if (t_blue > TALLY_MIN)
            lbl = 4'd2;
        else if (t_yellow > TALLY_MIN)
            lbl = 4'd3;
        else if (t_red > TALLY_MIN && t_black > TALLY_MIN)
            lbl = 4'd4;
        else if (t_red > TALLY_MIN)
            lbl = 4'd7;
        else
            lbl = 4'd0;
        return lbl;
    endfunction

    rect_t  item_r [RECT_NUM];
    tally_t tally  [RECT_NUM][6];
    logic   win_start;
    logic   win_end;
    logic   sample;

    assign win_start = i_valid && i_in_win && (i_x == WIN_X1) && (i_y == WIN_Y1);
    assign win_end   = i_valid && i_in_win && (i_x == WIN_X2) && (i_y == WIN_Y2);
    assign sample    = i_valid && i_in_win &&
                       ((i_x & SAMPLE_MASK) == '0) && ((i_y & SAMPLE_MASK) == '0);

    // ****************************************
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            for (int k = 0; k < RECT_NUM; k++) begin
                item_r[k] <= '0;
                for (int c = 0; c < 6; c++)
                    tally[k][c] <= '0;
            end
            o_item       <= '0;
            o_label      <= '0;
            o_frame_done <= 1'b0;
        end else begin
            o_frame_done <= win_end;
            for (int k = 0; k < RECT_NUM; k++) begin
                if (win_start) begin
                    // new frame, take fresh rectangles
                    item_r[k] <= i_item[k*32 +: 32];
                    for (int c = 0; c < 6; c++)
                        tally[k][c] <= '0;
                    // the start pixel is itself a sample
                    if (sample && in_rect(i_item[k*32 +: 32], i_x, i_y))
                        tally[k][i_color] <= 8'd1;
                end else if (sample && in_rect(item_r[k], i_x, i_y)) begin
                    // saturate at full scale
                    if (tally[k][i_color] != '1)
                        tally[k][i_color] <= tally[k][i_color] + 1'b1;
                end else if (win_end) begin
                    o_item[k*32 +: 32] <= item_r[k];
                    o_label[k*4 +: 4]  <= pick_label(tally[k][COL_RED], tally[k][COL_GREEN],
                                                     tally[k][COL_BLUE], tally[k][COL_YELLOW],
                                                     tally[k][COL_BLACK]);
                end
            end
        end
    end

endmodule

// File: logic/shelf_pkg.sv
package shelf_pkg;

    localparam int RECT_NUM = 4;

    typedef logic [15:0]            pix_t;
    typedef logic [5:0]             chan_t;
    typedef logic [7:0]             sum_t;
    typedef logic [7:0]             coord_t;
    typedef logic [31:0]            rect_t;
    typedef logic [RECT_NUM*32-1:0] rect_bus_t;
    typedef logic [3:0]             label_t;
    typedef logic [RECT_NUM*4-1:0]  label_bus_t;
    typedef logic [7:0]             tally_t;
    typedef logic [7:0]             byte_t;

    typedef enum logic [2:0] {
        COL_RED, COL_GREEN, COL_BLUE, COL_YELLOW, COL_WHITE, COL_BLACK
    } color_t;

    typedef enum logic [2:0] {
        MODE_FREE, MODE_GET, MODE_PUT, MODE_PAY, MODE_WARN
    } mode_t;

    // frame and inspection window, in pixels
    localparam int     FRAME_W = 64;
    localparam int     FRAME_H = 48;
    localparam coord_t WIN_X1  = 8'd8;
    localparam coord_t WIN_X2  = 8'd55;
    localparam coord_t WIN_Y1  = 8'd8;
    localparam coord_t WIN_Y2  = 8'd39;

    // one sample every 8 pixels in x and y
    localparam coord_t SAMPLE_MASK = 8'h07;
    localparam tally_t TALLY_MIN   = 8'd4;

    // reference hues as {r, g, b}, 6 bits per channel
    localparam logic [17:0] PAL_RED    = {6'd63, 6'd0,  6'd0};
    localparam logic [17:0] PAL_GREEN  = {6'd0,  6'd63, 6'd0};
    localparam logic [17:0] PAL_BLUE   = {6'd0,  6'd0,  6'd63};
    localparam logic [17:0] PAL_YELLOW = {6'd32, 6'd32, 6'd0};

    // display colors, rotated so each class stands out
    localparam pix_t SHOW_RED    = 16'h07E0;
    localparam pix_t SHOW_GREEN  = 16'h001F;
    localparam pix_t SHOW_BLUE   = 16'hF800;
    localparam pix_t SHOW_YELLOW = 16'h8410;
    localparam pix_t SHOW_WHITE  = 16'h0000;
    localparam pix_t SHOW_BLACK  = 16'hFFFF;

    localparam byte_t PRICE_1 = 8'd2;
    localparam byte_t PRICE_2 = 8'd2;
    localparam byte_t PRICE_3 = 8'd2;
    localparam byte_t PRICE_4 = 8'd4;
    localparam byte_t PRICE_7 = 8'd2;

    localparam byte_t USER_NONE    = 8'd0;
    localparam byte_t USER_RESTOCK = 8'd99;

    localparam int HOLD_CYCLES = 200;

endpackage

// File: logic/shelf_top.sv
`timescale 1ns/1ps

module shelf_top import shelf_pkg::*; (
    input  logic       sys_clk,
    input  logic       sys_rst_n,
    input  sum_t       i_match_err,
    input  sum_t       i_v_min,
    input  sum_t       i_v_max,
    input  sum_t       i_white_min,
    input  rect_bus_t  i_item,
    input  byte_t      i_user,
    input  logic       i_valid,
    input  pix_t       i_pix,
    output logic       o_valid,
    output pix_t       o_pix,
    output rect_bus_t  o_item,
    output label_bus_t o_label,
    output byte_t      o_num,
    output byte_t      o_money,
    output byte_t      o_payment,
    output byte_t      o_user,
    output mode_t      o_pattern
);

    logic   loc_valid;
    coord_t loc_x;
    coord_t loc_y;
    logic   loc_in_win;
    color_t pix_color;
    logic   frame_done;

    pixel_locator u_pixel_locator (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .i_valid   (i_valid),
        .o_valid   (loc_valid),
        .o_x       (loc_x),
        .o_y       (loc_y),
        .o_in_win  (loc_in_win)
    );

    color_classifier u_color_classifier (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .i_valid     (i_valid),
        .i_pix       (i_pix),
        .i_in_win    (loc_in_win),
        .i_match_err (i_match_err),
        .i_v_min     (i_v_min),
        .i_v_max     (i_v_max),
        .i_white_min (i_white_min),
        .o_color     (pix_color),
        .o_valid     (o_valid),
        .o_pix       (o_pix)
    );

    rect_tally u_rect_tally (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .i_valid      (loc_valid),
        .i_x          (loc_x),
        .i_y          (loc_y),
        .i_in_win     (loc_in_win),
        .i_color      (pix_color),
        .i_item       (i_item),
        .o_item       (o_item),
        .o_label      (o_label),
        .o_frame_done (frame_done)
    );

    checkout_ctrl u_checkout_ctrl (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .i_frame_done (frame_done),
        .i_label      (o_label),
        .i_user       (i_user),
        .o_num        (o_num),
        .o_money      (o_money),
        .o_payment    (o_payment),
        .o_user       (o_user),
        .o_pattern    (o_pattern)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the shelf testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps --top-module tb_shelf \
    -f flist.f -o tb_shelf \
    || { echo "verilator build failed"; exit 1; }
result=$(./obj_dir/tb_shelf)
echo "$result"
grep -qxF '** PASS **' <<< "$result" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: sim/shelf_cases.txt
# bg fill0 fill1 fill2 fill3 rect0 rect1 rect2 rect3 user labels num money payment pattern
# all hex; rect is x1 y1 x2 y2 in 4-pixel units; pattern 0 free 1 get 2 put 3 pay 4 warn
FFFF 07E0 001F 8400 F800 02020604 08020C04 02060608 08060C08 00 7321 04 08 00 0
FFFF F800 0000 FFFF FFFF 02020604 02020C08 00000000 00000000 00 0047 00 00 00 4
FFFF F800 0000 FFFF FFFF 02020604 02020C08 00000000 00000000 00 0047 02 00 00 0
FFFF F800 0000 FFFF FFFF 02020604 02020C08 00000000 00000000 00 0047 02 06 00 0
FFFF F800 0000 FFFF FFFF 02020604 02020C08 00000000 00000000 05 0047 02 06 00 1
FFFF F800 FFFF FFFF FFFF 02020604 00000000 00000000 00000000 05 0007 02 06 00 1
FFFF F800 FFFF FFFF FFFF 02020604 00000000 00000000 00000000 00 0007 02 06 04 3
FFFF F800 FFFF FFFF FFFF 02020604 00000000 00000000 00000000 00 0007 01 06 04 0
FFFF F800 FFFF FFFF FFFF 02020604 00000000 00000000 00000000 00 0007 01 02 00 0
FFFF 07E0 001F 8400 F800 02020604 08020C04 02060608 08060C08 63 7321 01 02 00 2
FFFF 07E0 001F 8400 F800 02020604 08020C04 02060608 08060C08 00 7321 04 02 00 0
FFFF 07E0 001F 8400 F800 02020604 08020C04 02060608 08060C08 00 7321 04 08 00 0

// File: sim/tb_shelf.sv
`timescale 1ns/1ps

module tb_shelf import shelf_pkg::*; ();

    localparam sum_t  MATCH_ERR   = 8'd16;
    localparam sum_t  V_MIN       = 8'd32;
    localparam sum_t  V_MAX       = 8'd100;
    localparam sum_t  WHITE_MIN   = 8'd120;
    localparam int    DRAIN_LIMIT = 200;
    localparam string CASE_FILE   = "sim/shelf_cases.txt";

    logic       sys_clk;
    logic       sys_rst_n;
    rect_bus_t  i_item;
    byte_t      i_user;
    logic       i_valid;
    pix_t       i_pix;
    logic       o_valid;
    pix_t       o_pix;
    rect_bus_t  o_item;
    label_bus_t o_label;
    byte_t      o_num;
    byte_t      o_money;
    byte_t      o_payment;
    byte_t      o_user;
    mode_t      o_pattern;

    // current case, as read from the case file
    pix_t       cur_bg;
    pix_t       cur_fill [RECT_NUM];
    rect_t      cur_rect [RECT_NUM];
    byte_t      cur_user;
    label_bus_t exp_label;
    byte_t      exp_num;
    byte_t      exp_money;
    byte_t      exp_pay;
    byte_t      exp_pat;
    byte_t      exp_user;
    byte_t      prev_pat;

    pix_t        exp_q[$];
    logic [15:0] lfsr_state;
    int          case_errs;
    int          pass_cases;
    int          fail_cases;
    bit          timed_out;

    shelf_top i_dut (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .i_match_err (MATCH_ERR),
        .i_v_min     (V_MIN),
        .i_v_max     (V_MAX),
        .i_white_min (WHITE_MIN),
        .i_item      (i_item),
        .i_user      (i_user),
        .i_valid     (i_valid),
        .i_pix       (i_pix),
        .o_valid     (o_valid),
        .o_pix       (o_pix),
        .o_item      (o_item),
        .o_label     (o_label),
        .o_num       (o_num),
        .o_money     (o_money),
        .o_payment   (o_payment),
        .o_user      (o_user),
        .o_pattern   (o_pattern)
    );

    always #2 sys_clk = ~sys_clk;

    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bit(output bit b);
        lfsr_state = lfsr_next(lfsr_state);
        b = lfsr_state[0];
    endtask

    // ****************************************
    // reference color rule
    function automatic bit near_hue(int r, int g, int b, int hr, int hg, int hb);
        int d;
        d = (r > hr ? r - hr : hr - r) + (g > hg ? g - hg : hg - g) +
            (b > hb ? b - hb : hb - b);
        return d <= MATCH_ERR;
    endfunction

    function automatic pix_t class_show(pix_t p);
        int   r;
        int   g;
        int   b;
        int   s;
        bit   in_v;
        pix_t show;
        r = 2 * p[15:11];
        g = p[10:5];
        b = 2 * p[4:0];
        s = r + g + b;
        in_v = (s >= V_MIN) && (s <= V_MAX);
        if (in_v && near_hue(r, g, b, 63, 0, 0))
            show = SHOW_RED;
        else if (in_v && near_hue(r, g, b, 0, 63, 0))
            show = SHOW_GREEN;
        else if (in_v && near_hue(r, g, b, 0, 0, 63))
            show = SHOW_BLUE;
        else if (in_v && near_hue(r, g, b, 32, 32, 0))
            show = SHOW_YELLOW;
        else if (s > WHITE_MIN)
            show = SHOW_WHITE;
        else
            show = SHOW_BLACK;
        return show;
    endfunction

    function automatic pix_t expect_pixel(int x, int y, pix_t p);
        if (x >= WIN_X1 && x <= WIN_X2 && y >= WIN_Y1 && y <= WIN_Y2)
            return class_show(p);
        return p;
    endfunction

    // lowest rectangle index is painted on top
    function automatic pix_t paint_pixel(int x, int y);
        pix_t p;
        p = cur_bg;
        for (int k = RECT_NUM - 1; k >= 0; k--) begin
            if (x / 4 >= cur_rect[k][31:24] && y / 4 >= cur_rect[k][23:16] &&
                x / 4 <= cur_rect[k][15:8] && y / 4 <= cur_rect[k][7:0])
                p = cur_fill[k];
        end
        return p;
    endfunction

    task automatic drive_frame();
        bit   b0;
        bit   b1;
        pix_t p;
        for (int y = 0; y < FRAME_H; y++) begin
            for (int x = 0; x < FRAME_W; x++) begin
                take_bit(b0);
                take_bit(b1);
                // idle cycle about one time in four
                if (b0 && b1) begin
                    @(posedge sys_clk);
                    #0.5;
                    i_valid = 1'b0;
                end
                p = paint_pixel(x, y);
                @(posedge sys_clk);
                #0.5;
                i_valid = 1'b1;
                i_pix   = p;
                exp_q.push_back(expect_pixel(x, y, p));
            end
        end
        @(posedge sys_clk);
        #0.5;
        i_valid = 1'b0;
    endtask

    task automatic check_field(input string name, input logic [127:0] got,
                               input logic [127:0] want);
        if (got !== want) begin
            $display("Error %s: got %0h expected %0h", name, got, want);
            case_errs++;
        end
    endtask

    // ****************************************
    task automatic run_case(input int idx);
        int        waited;
        rect_bus_t want_item;
        case_errs = 0;
        // shown user is the buyer, then whoever stands there after payment
        if (prev_pat == MODE_FREE && exp_pat == MODE_GET)
            exp_user = cur_user;
        else if (prev_pat == MODE_PAY && exp_pat == MODE_FREE)
            exp_user = cur_user;
        prev_pat = exp_pat;
        for (int k = 0; k < RECT_NUM; k++)
            want_item[k*32 +: 32] = cur_rect[k];
        @(posedge sys_clk);
        #0.5;
        i_item = want_item;
        i_user = cur_user;
        drive_frame();
        waited = 0;
        while (exp_q.size() > 0 && waited < DRAIN_LIMIT) begin
            @(posedge sys_clk);
            waited++;
        end
        if (exp_q.size() > 0) begin
            $display("case %0d timed out waiting for output pixels", idx);
            timed_out = 1'b1;
            case_errs++;
        end else begin
            @(negedge sys_clk);
            check_field("o_item", o_item, want_item);
            check_field("o_label", o_label, exp_label);
            check_field("o_num", o_num, exp_num);
            check_field("o_money", o_money, exp_money);
            check_field("o_payment", o_payment, exp_pay);
            check_field("o_user", o_user, exp_user);
            check_field("o_pattern", o_pattern, exp_pat);
        end
        if (case_errs == 0) begin
            pass_cases++;
            $display("case %0d passed", idx);
        end else begin
            fail_cases++;
            $display("case %0d failed with %0d errors", idx, case_errs);
        end
    endtask

    // output pixels come back in input order
    always @(negedge sys_clk) begin
        pix_t want;
        if (o_valid) begin
            if (exp_q.size() == 0) begin
                $display("an output pixel arrived with no input pixel pending");
                case_errs++;
            end else begin
                want = exp_q.pop_front();
                if (o_pix !== want) begin
                    $display("Error o_pix: got %h expected %h", o_pix, want);
                    case_errs++;
                end
            end
        end
    end

    initial begin
        int    fd;
        int    n;
        int    idx;
        string line;
        sys_clk    = 1'b0;
        sys_rst_n  = 1'b0;
        i_item     = '0;
        i_user     = '0;
        i_valid    = 1'b0;
        i_pix      = '0;
        lfsr_state = 16'd20;
        pass_cases = 0;
        fail_cases = 0;
        timed_out  = 1'b0;
        exp_user   = '0;
        prev_pat   = MODE_FREE;
        idx        = 0;
        repeat (16) @(posedge sys_clk);
        #0.5;
        sys_rst_n = 1'b1;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("could not open %s", CASE_FILE);
            fail_cases++;
        end else begin
            while (!timed_out && $fgets(line, fd) > 0) begin
                if (line.len() < 10 || line.getc(0) == "#")
                    continue;
                idx++;
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            cur_bg, cur_fill[0], cur_fill[1], cur_fill[2], cur_fill[3],
                            cur_rect[0], cur_rect[1], cur_rect[2], cur_rect[3], cur_user,
                            exp_label, exp_num, exp_money, exp_pay, exp_pat);
                if (n != 15) begin
                    $display("case line %0d could not be read", idx);
                    fail_cases++;
                end else begin
                    run_case(idx);
                end
            end
            $fclose(fd);
        end
        $display("%0d cases, %0d passed, %0d failed", idx, pass_cases, fail_cases);
        if (fail_cases == 0 && pass_cases > 0 && !timed_out)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule
